//--- hdl/scan_io_pkg.sv
// Shared constants and types for the scan converter core; imported by every design module
package scan_io_pkg;

    // Video bus
    localparam int COLOR_W = 8;

    // PWM counter and duty fields, period is 2**PWM_CNT_W cycles
    localparam int PWM_CNT_W = 6;
    localparam int DUTY_W = 4;

    // Resync LED stretch length
    localparam int RESYNC_CTR_W = 8;

    localparam int BTN_W = 6;
    localparam int NUM_LEDS = 2;

    // OSD palette, packed as {r, g, b}
    localparam logic [3*COLOR_W-1:0] OSD_BLACK = 24'h000000;
    localparam logic [3*COLOR_W-1:0] OSD_BLUE = 24'h0000ff;
    localparam logic [3*COLOR_W-1:0] OSD_YELLOW = 24'hffff00;
    localparam logic [3*COLOR_W-1:0] OSD_WHITE = 24'hffffff;

    // One pixel with its sync and blanking flags
    typedef struct packed {
        logic [COLOR_W-1:0] r;
        logic [COLOR_W-1:0] g;
        logic [COLOR_W-1:0] b;
        logic hsync;
        logic vsync;
        logic de;
    } video_pix_t;

    // System control word from the CPU, MSB first
    typedef struct packed {
        logic [7:0] rsvd_31_24;
        logic [DUTY_W-1:0] led_duty;
        logic [DUTY_W-1:0] fan_duty;
        logic rsvd_15;
        logic framelock;
        logic [5:0] rsvd_13_8;
        // 1 selects HDMI receiver
        logic capture_sel;
        logic [3:0] rsvd_6_3;
        logic hdmirx_reset_n;
        logic isl_reset_n;
        logic sys_poweron;
    } sys_ctrl_t;

endpackage

//--- hdl/input_sync.sv
// Generic register chain of STAGES flops for input sampling and synchronizing any payload type
`timescale 1ns/1ps

module input_sync #(
    parameter type payload_t = logic,
    parameter int STAGES = 2,
    parameter payload_t RESET_VAL = '0
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t stage_q [STAGES];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < STAGES; i++) begin
                stage_q[i] <= RESET_VAL;
            end
        end else begin
            stage_q[0] <= d_i;
            for (int i = 1; i < STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign q_o = stage_q[STAGES-1];

endmodule

//--- hdl/capture_mux.sv
// Frame capture point; registers either the digitizer or the HDMI receiver pixel
`timescale 1ns/1ps

module capture_mux
    import scan_io_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       capture_sel_i,
    input  video_pix_t isl_pix_i,
    input  video_pix_t hdmirx_pix_i,
    output video_pix_t capt_pix_o
);

    video_pix_t capt_pix_q;

    // High selects HDMI
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            capt_pix_q <= '0;
        end else if (capture_sel_i) begin
            capt_pix_q <= hdmirx_pix_i;
        end else begin
            capt_pix_q <= isl_pix_i;
        end
    end

    assign capt_pix_o = capt_pix_q;

endmodule

//--- hdl/osd_out_stage.sv
// OSD colour overlay followed by the output pad register, two cycles in total
`timescale 1ns/1ps

module osd_out_stage
    import scan_io_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  video_pix_t pix_i,
    input  logic       osd_enable_i,
    input  logic [1:0] osd_color_i,
    output video_pix_t vid_o
);

    logic [3*COLOR_W-1:0] osd_rgb;
    video_pix_t out_q;
    video_pix_t pad_q;

    always_comb begin
        case (osd_color_i)
            2'd0: osd_rgb = OSD_BLACK;
            2'd1: osd_rgb = OSD_BLUE;
            2'd2: osd_rgb = OSD_YELLOW;
            default: osd_rgb = OSD_WHITE;
        endcase
    end

    // Stage 1, colour replaced but syncs untouched
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q <= '0;
        end else begin
            if (osd_enable_i) begin
                {out_q.r, out_q.g, out_q.b} <= osd_rgb;
            end else begin
                {out_q.r, out_q.g, out_q.b} <= {pix_i.r, pix_i.g, pix_i.b};
            end
            out_q.hsync <= pix_i.hsync;
            out_q.vsync <= pix_i.vsync;
            out_q.de <= pix_i.de;
        end
    end

    // Stage 2, pad register
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pad_q <= '0;
        end else begin
            pad_q <= out_q;
        end
    end

    assign vid_o = pad_q;

endmodule

//--- hdl/pwm_2ch.sv
// Two PWM channels sharing one free-running counter; drives fan and LED brightness
`timescale 1ns/1ps

module pwm_2ch
    import scan_io_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic [DUTY_W-1:0] ch1_duty_i,
    input  logic [DUTY_W-1:0] ch2_duty_i,
    output logic              ch1_pwm_o,
    output logic              ch2_pwm_o
);

    logic [PWM_CNT_W-1:0] pwm_cnt;
    logic [DUTY_W-1:0] cnt_msbs;

    // Wraps naturally every 2**PWM_CNT_W cycles
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
        end
    end

    // Compare on the top bits only, so duty 0 is always off
    assign cnt_msbs = pwm_cnt[PWM_CNT_W-1 -: DUTY_W];

    assign ch1_pwm_o = (cnt_msbs < ch1_duty_i);
    assign ch2_pwm_o = (cnt_msbs < ch2_duty_i);

endmodule

//--- hdl/board_ctrl.sv
// Control word decode, resync LED stretcher and LED/fan drive for the board
`timescale 1ns/1ps

module board_ctrl
    import scan_io_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  sys_ctrl_t           sys_ctrl_i,
    input  logic                resync_strobe_i,
    input  logic                fan_pwm_i,
    input  logic                led_pwm_i,
    output logic                capture_sel_o,
    output logic [DUTY_W-1:0]   fan_duty_o,
    output logic [DUTY_W-1:0]   led_duty_o,
    output logic                isl_reset_n_o,
    output logic                hdmirx_reset_n_o,
    output logic                hdmitx_5v_en_o,
    output logic                fan_pwm_o,
    output logic [NUM_LEDS-1:0] led_o
);

    logic strobe_sync;
    logic strobe_prev;
    logic strobe_rise;
    logic [RESYNC_CTR_W-1:0] resync_led_ctr;
    logic resync_active;
    logic [NUM_LEDS-1:0] led_mask;

    // Strobe comes from the scaler, treat as async
    input_sync #(
        .payload_t (logic),
        .STAGES    (2),
        .RESET_VAL (1'b0)
    ) i_strobe_sync (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .d_i     (resync_strobe_i),
        .q_o     (strobe_sync)
    );

    assign strobe_rise = strobe_sync & ~strobe_prev;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            strobe_prev <= 1'b0;
            resync_led_ctr <= '0;
        end else begin
            strobe_prev <= strobe_sync;
            if (!sys_ctrl_i.sys_poweron) begin
                resync_led_ctr <= '0;
            end else if (strobe_rise) begin
                resync_led_ctr <= '1;
            end else if (resync_led_ctr != '0) begin
                resync_led_ctr <= resync_led_ctr - 1'b1;
            end
        end
    end

    assign resync_active = (resync_led_ctr != '0);

    // Standby shows only the power LED
    assign led_mask = sys_ctrl_i.sys_poweron ? {sys_ctrl_i.framelock, resync_active}
                                             : {1'b0, 1'b1};
    assign led_o = {NUM_LEDS{led_pwm_i}} & led_mask;

    // Fan driver input is active low
    assign fan_pwm_o = ~(sys_ctrl_i.sys_poweron & fan_pwm_i);

    assign capture_sel_o = sys_ctrl_i.capture_sel;
    assign fan_duty_o = sys_ctrl_i.fan_duty;
    assign led_duty_o = sys_ctrl_i.led_duty;
    assign isl_reset_n_o = sys_ctrl_i.isl_reset_n;
    assign hdmirx_reset_n_o = sys_ctrl_i.hdmirx_reset_n;
    assign hdmitx_5v_en_o = sys_ctrl_i.sys_poweron;

endmodule

//--- hdl/scan_io_top.sv
// Scan converter core top level; connects board control to the video and PWM datapath
`timescale 1ns/1ps

module scan_io_top
    import scan_io_pkg::*;
(
    input  logic                pclk_out,
    input  logic                po_reset_n,
    input  sys_ctrl_t           sys_ctrl_i,
    input  video_pix_t          isl_pix_i,
    input  video_pix_t          hdmirx_pix_i,
    input  logic                osd_enable_i,
    input  logic [1:0]          osd_color_i,
    input  logic                resync_strobe_i,
    input  logic [BTN_W-1:0]    btn_i,
    output video_pix_t          vid_o,
    output logic [BTN_W-1:0]    btn_o,
    output logic [NUM_LEDS-1:0] led_o,
    output logic                fan_pwm_o,
    output logic                isl_reset_n_o,
    output logic                hdmirx_reset_n_o,
    output logic                hdmitx_5v_en_o
);

    video_pix_t isl_pix;
    video_pix_t hdmirx_pix;
    video_pix_t capt_pix;
    logic capture_sel;
    logic [DUTY_W-1:0] fan_duty;
    logic [DUTY_W-1:0] led_duty;
    logic fan_pwm;
    logic led_pwm;

    board_ctrl i_board_ctrl (
        .clk_i            (pclk_out),
        .rst_n_i          (po_reset_n),
        .sys_ctrl_i       (sys_ctrl_i),
        .resync_strobe_i  (resync_strobe_i),
        .fan_pwm_i        (fan_pwm),
        .led_pwm_i        (led_pwm),
        .capture_sel_o    (capture_sel),
        .fan_duty_o       (fan_duty),
        .led_duty_o       (led_duty),
        .isl_reset_n_o    (isl_reset_n_o),
        .hdmirx_reset_n_o (hdmirx_reset_n_o),
        .hdmitx_5v_en_o   (hdmitx_5v_en_o),
        .fan_pwm_o        (fan_pwm_o),
        .led_o            (led_o)
    );

    // Digitizer gets one input register, HDMI receiver two
    input_sync #(.payload_t(video_pix_t), .STAGES(1), .RESET_VAL('0)) i_isl_sync (
        .clk_i   (pclk_out),
        .rst_n_i (po_reset_n),
        .d_i     (isl_pix_i),
        .q_o     (isl_pix)
    );

    input_sync #(.payload_t(video_pix_t), .STAGES(2), .RESET_VAL('0)) i_hdmirx_sync (
        .clk_i   (pclk_out),
        .rst_n_i (po_reset_n),
        .d_i     (hdmirx_pix_i),
        .q_o     (hdmirx_pix)
    );

    // Buttons idle high
    input_sync #(
        .payload_t (logic [BTN_W-1:0]),
        .STAGES    (2),
        .RESET_VAL ({BTN_W{1'b1}})
    ) i_btn_sync (
        .clk_i   (pclk_out),
        .rst_n_i (po_reset_n),
        .d_i     (btn_i),
        .q_o     (btn_o)
    );

    capture_mux i_capture_mux (
        .clk_i         (pclk_out),
        .rst_n_i       (po_reset_n),
        .capture_sel_i (capture_sel),
        .isl_pix_i     (isl_pix),
        .hdmirx_pix_i  (hdmirx_pix),
        .capt_pix_o    (capt_pix)
    );

    osd_out_stage i_osd_out_stage (
        .clk_i        (pclk_out),
        .rst_n_i      (po_reset_n),
        .pix_i        (capt_pix),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .vid_o        (vid_o)
    );

    pwm_2ch i_pwm_2ch (
        .clk_i      (pclk_out),
        .rst_n_i    (po_reset_n),
        .ch1_duty_i (fan_duty),
        .ch2_duty_i (led_duty),
        .ch1_pwm_o  (fan_pwm),
        .ch2_pwm_o  (led_pwm)
    );

endmodule

//--- verif/scan_io_assertions.sv
// Concurrent checks on the board control outputs, bound into board_ctrl
`timescale 1ns/1ps

module scan_io_assertions
    import scan_io_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  sys_ctrl_t               sys_ctrl_i,
    input  logic                    led_pwm_i,
    input  logic [NUM_LEDS-1:0]     led_i,
    input  logic                    hdmitx_5v_en_i,
    input  logic [RESYNC_CTR_W-1:0] resync_ctr_i
);

    int unsigned fail_count = 0;

    a_5v_follows_power: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        hdmitx_5v_en_i == sys_ctrl_i.sys_poweron)
    else begin
        fail_count++;
        $error("HDMI TX 5V enable differs from sys_poweron");
    end

    // LEDs are gated by the LED PWM channel
    a_led_gated_by_pwm: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !led_pwm_i |-> led_i == '0)
    else begin
        fail_count++;
        $error("LED lit while the LED PWM channel is low");
    end

    // Counter clears on the edge after power goes off
    a_ctr_idle_power_off: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !sys_ctrl_i.sys_poweron |=> resync_ctr_i == '0)
    else begin
        fail_count++;
        $error("Resync LED counter not zero while power is off");
    end

endmodule

bind board_ctrl scan_io_assertions i_board_asrt (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .sys_ctrl_i     (sys_ctrl_i),
    .led_pwm_i      (led_pwm_i),
    .led_i          (led_o),
    .hdmitx_5v_en_i (hdmitx_5v_en_o),
    .resync_ctr_i   (resync_led_ctr)
);

//--- verif/scan_io_checker.sv
// Reference model and scoreboard for the scan converter core, instantiated beside the DUT
`timescale 1ns/1ps

module scan_io_checker
    import scan_io_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic [1:0]          row_kind_i,
    input  logic                row_last_i,
    input  sys_ctrl_t           sys_ctrl_i,
    input  video_pix_t          isl_pix_i,
    input  video_pix_t          hdmirx_pix_i,
    input  logic                osd_enable_i,
    input  logic [1:0]          osd_color_i,
    input  logic                resync_strobe_i,
    input  logic [BTN_W-1:0]    btn_i,
    input  video_pix_t          dut_vid_i,
    input  logic [BTN_W-1:0]    dut_btn_i,
    input  logic [NUM_LEDS-1:0] dut_led_i,
    input  logic                dut_fan_i,
    input  logic                dut_isl_rst_n_i,
    input  logic                dut_hdmirx_rst_n_i,
    input  logic                dut_5v_en_i,
    output int                  error_count_o
);

    logic [5:0] pwm_ref;
    logic first_sample;
    logic strobe_seen;
    int since_strobe;
    int fan_low_cnt;
    int led_high_cnt;
    int errors = 0;

    assign error_count_o = errors;

    task automatic report(input string msg);
        errors++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    function automatic video_pix_t expected_pix();
        video_pix_t p;
        p = sys_ctrl_i.capture_sel ? hdmirx_pix_i : isl_pix_i;
        if (osd_enable_i) begin
            case (osd_color_i)
                2'd0: {p.r, p.g, p.b} = 24'h000000;
                2'd1: {p.r, p.g, p.b} = 24'h0000ff;
                2'd2: {p.r, p.g, p.b} = 24'hffff00;
                default: {p.r, p.g, p.b} = 24'hffffff;
            endcase
        end
        return p;
    endfunction

    // Row kinds: 0 video, 1 PWM, 2 resync, 3 power off
    task automatic check_sample();
        video_pix_t exp_vid;
        logic led_ref;
        led_ref = (pwm_ref[5:2] < sys_ctrl_i.led_duty);
        if (first_sample) begin
            if (dut_vid_i !== '0) report("vid_o not zero after reset");
            if (dut_btn_i !== '1) report("btn_o not all ones after reset");
            first_sample = 1'b0;
        end
        if (dut_isl_rst_n_i != sys_ctrl_i.isl_reset_n ||
            dut_hdmirx_rst_n_i != sys_ctrl_i.hdmirx_reset_n ||
            dut_5v_en_i != sys_ctrl_i.sys_poweron) begin
            report("chip reset or 5V enable differs from the control word");
        end
        if (resync_strobe_i && !strobe_seen) begin
            strobe_seen = 1'b1;
            since_strobe = 0;
        end else if (strobe_seen) begin
            since_strobe++;
        end
        if (!dut_fan_i) fan_low_cnt++;
        if (dut_led_i[1]) led_high_cnt++;
        if (row_kind_i == 2'd3) begin
            if (dut_led_i != {1'b0, led_ref}) report("led_o wrong while power is off");
            if (!dut_fan_i) report("fan driven while power is off");
        end else begin
            if (dut_led_i[1] != (sys_ctrl_i.framelock & led_ref)) report("framelock LED wrong");
        end
        if (row_kind_i != 2'd2 || !strobe_seen) begin
            if (dut_led_i[0] && sys_ctrl_i.sys_poweron) report("resync LED on without a strobe");
        end else begin
            // Stretch of 255 to 258 cycles, starting 3 to 6 samples after the strobe
            if (dut_led_i[0] && (since_strobe < 3 || since_strobe > 260))
                report("resync LED on outside its stretch window");
            if (dut_led_i[1] && !dut_led_i[0] && since_strobe >= 6 && since_strobe <= 257)
                report("resync LED dropped inside its stretch window");
        end
        if (row_last_i) begin
            exp_vid = expected_pix();
            if (dut_vid_i !== exp_vid)
                report($sformatf("vid_o %h, expected %h", dut_vid_i, exp_vid));
            if (dut_btn_i !== btn_i)
                report($sformatf("btn_o %h, expected %h", dut_btn_i, btn_i));
            if (row_kind_i == 2'd1 && fan_low_cnt != 8 * sys_ctrl_i.fan_duty)
                report($sformatf("fan on for %0d cycles, expected %0d",
                                 fan_low_cnt, 8 * sys_ctrl_i.fan_duty));
            if (row_kind_i == 2'd1 && led_high_cnt != 8 * sys_ctrl_i.led_duty)
                report($sformatf("LED on for %0d cycles, expected %0d",
                                 led_high_cnt, 8 * sys_ctrl_i.led_duty));
            fan_low_cnt = 0;
            led_high_cnt = 0;
            strobe_seen = 1'b0;
        end
    endtask

    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pwm_ref = '0;
            first_sample = 1'b1;
            strobe_seen = 1'b0;
            since_strobe = 0;
            fan_low_cnt = 0;
            led_high_cnt = 0;
        end else begin
            check_sample();
            // PWM reference counter, wraps every 64 cycles
            pwm_ref = pwm_ref + 1'b1;
        end
    end

endmodule

//--- verif/tb_scan_io.sv
// Testbench for the scan converter core; applies the stimulus table and reports the result
`timescale 1ns/1ps

module tb_scan_io
    import scan_io_pkg::*;
();

    typedef struct packed {
        logic [31:0]      ctrl;
        logic             osd_en;
        logic [1:0]       osd_color;
        logic             strobe;
        logic [BTN_W-1:0] btn;
        logic [1:0]       kind;
        logic [15:0]      hold;
    } row_t;

    localparam int NUM_ROWS = 14;
    // Control word, OSD enable, OSD colour, strobe, buttons, kind, hold cycles
    localparam row_t ROWS [NUM_ROWS] = '{
        '{32'h0000_0007, 1'b0, 2'd0, 1'b0, 6'h3f, 2'd0, 16'd8},
        '{32'h0000_0087, 1'b0, 2'd0, 1'b0, 6'h2a, 2'd0, 16'd8},
        '{32'h0000_0007, 1'b0, 2'd0, 1'b0, 6'h15, 2'd0, 16'd8},
        '{32'h0000_0007, 1'b1, 2'd0, 1'b0, 6'h3e, 2'd0, 16'd8},
        '{32'h0000_0087, 1'b1, 2'd1, 1'b0, 6'h3d, 2'd0, 16'd8},
        '{32'h0000_0007, 1'b1, 2'd2, 1'b0, 6'h3b, 2'd0, 16'd8},
        '{32'h0000_0087, 1'b1, 2'd3, 1'b0, 6'h37, 2'd0, 16'd8},
        '{32'h0095_4007, 1'b0, 2'd0, 1'b0, 6'h2f, 2'd1, 16'd128},
        '{32'h000f_4087, 1'b0, 2'd0, 1'b0, 6'h1f, 2'd1, 16'd128},
        '{32'h00c0_4007, 1'b0, 2'd0, 1'b0, 6'h00, 2'd1, 16'd128},
        '{32'h00f0_4007, 1'b0, 2'd0, 1'b1, 6'h3f, 2'd2, 16'd320},
        '{32'h006a_4002, 1'b0, 2'd0, 1'b1, 6'h0f, 2'd3, 16'd128},
        '{32'h00ff_4000, 1'b0, 2'd0, 1'b0, 6'h30, 2'd3, 16'd128},
        '{32'h0000_0087, 1'b0, 2'd0, 1'b0, 6'h3f, 2'd0, 16'd8}
    };

    logic pclk_out = 1'b0;
    logic po_reset_n;
    sys_ctrl_t sys_ctrl;
    video_pix_t isl_pix;
    video_pix_t hdmirx_pix;
    logic osd_enable;
    logic [1:0] osd_color;
    logic resync_strobe;
    logic [BTN_W-1:0] btn;
    video_pix_t vid;
    logic [BTN_W-1:0] btn_out;
    logic [NUM_LEDS-1:0] led;
    logic fan_pwm;
    logic isl_reset_n;
    logic hdmirx_reset_n;
    logic hdmitx_5v_en;
    logic [1:0] row_kind;
    logic row_last;
    logic [15:0] lfsr_q;
    int chk_errors;
    int cycles = 0;
    int cycle_limit = 0;

    always #4 pclk_out = ~pclk_out;

    scan_io_top i_dut (
        .pclk_out         (pclk_out),
        .po_reset_n       (po_reset_n),
        .sys_ctrl_i       (sys_ctrl),
        .isl_pix_i        (isl_pix),
        .hdmirx_pix_i     (hdmirx_pix),
        .osd_enable_i     (osd_enable),
        .osd_color_i      (osd_color),
        .resync_strobe_i  (resync_strobe),
        .btn_i            (btn),
        .vid_o            (vid),
        .btn_o            (btn_out),
        .led_o            (led),
        .fan_pwm_o        (fan_pwm),
        .isl_reset_n_o    (isl_reset_n),
        .hdmirx_reset_n_o (hdmirx_reset_n),
        .hdmitx_5v_en_o   (hdmitx_5v_en)
    );

    scan_io_checker i_chk (
        .clk_i              (pclk_out),
        .rst_n_i            (po_reset_n),
        .row_kind_i         (row_kind),
        .row_last_i         (row_last),
        .sys_ctrl_i         (sys_ctrl),
        .isl_pix_i          (isl_pix),
        .hdmirx_pix_i       (hdmirx_pix),
        .osd_enable_i       (osd_enable),
        .osd_color_i        (osd_color),
        .resync_strobe_i    (resync_strobe),
        .btn_i              (btn),
        .dut_vid_i          (vid),
        .dut_btn_i          (btn_out),
        .dut_led_i          (led),
        .dut_fan_i          (fan_pwm),
        .dut_isl_rst_n_i    (isl_reset_n),
        .dut_hdmirx_rst_n_i (hdmirx_reset_n),
        .dut_5v_en_i        (hdmitx_5v_en),
        .error_count_o      (chk_errors)
    );

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic draw_pixel(output video_pix_t p);
        for (int i = 0; i < $bits(video_pix_t); i++) begin
            p = {p[$bits(video_pix_t)-2:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic apply_row(input row_t row);
        video_pix_t pix;
        sys_ctrl = row.ctrl;
        osd_enable = row.osd_en;
        osd_color = row.osd_color;
        resync_strobe = row.strobe;
        btn = row.btn;
        draw_pixel(pix);
        isl_pix = pix;
        draw_pixel(pix);
        hdmirx_pix = pix;
        row_kind = row.kind;
        row_last = 1'b0;
    endtask

    always @(posedge pclk_out) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        int asrt_errors;
        for (int i = 0; i < NUM_ROWS; i++) begin
            cycle_limit += ROWS[i].hold;
        end
        cycle_limit += 5 + 50;
        lfsr_q = 16'd60;
        po_reset_n = 1'b0;
        sys_ctrl = '0;
        isl_pix = '0;
        hdmirx_pix = '0;
        osd_enable = 1'b0;
        osd_color = 2'd0;
        resync_strobe = 1'b0;
        btn = '1;
        row_kind = 2'd0;
        row_last = 1'b0;
        repeat (5) @(negedge pclk_out);
        po_reset_n = 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(ROWS[i]);
            for (int c = 1; c < ROWS[i].hold; c++) begin
                @(negedge pclk_out);
                resync_strobe = 1'b0;
                row_last = (c == ROWS[i].hold - 1);
            end
            @(negedge pclk_out);
        end
        asrt_errors = i_dut.i_board_ctrl.i_board_asrt.fail_count;
        $display("Errors: %0d from the checker, %0d from assertions", chk_errors, asrt_errors);
        if (chk_errors == 0 && asrt_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
hdl/scan_io_pkg.sv
hdl/input_sync.sv
hdl/capture_mux.sv
hdl/osd_out_stage.sv
hdl/pwm_2ch.sv
hdl/board_ctrl.sv
hdl/scan_io_top.sv
verif/scan_io_assertions.sv
verif/scan_io_checker.sv
verif/tb_scan_io.sv
